/* design/nnPkg.sv */
`default_nettype none

package nnPkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int featureCount = 30;
	localparam int neuronCount = 4;
	localparam int dataWidth = 8;
	localparam int productWidth = 16;
	localparam int sumWidth = 23;
	localparam int classWidth = 2;
	localparam int fracBits = 6;
	localparam logic [dataWidth-1:0] satLevel = 8'd127;

	// ------------------------------------------------------------------------
	// stream and vector types
	// ------------------------------------------------------------------------
	typedef enum logic {
		featStart,
		featData
	} featureKind;

	typedef struct packed {
		featureKind kind;
		logic [dataWidth-1:0] data; // ignored on featStart
	} featureWord;

	// element 0 sits in the top byte
	typedef struct packed {
		logic [0:featureCount-1][dataWidth-1:0] feature;
	} featureVector;

	typedef struct packed {
		logic [0:neuronCount-1][dataWidth-1:0] activation;
	} layerOutput;

	typedef struct packed {
		logic [classWidth-1:0] classIndex;
		logic [dataWidth-1:0] score;
	} classResult;

	// ------------------------------------------------------------------------
	// fixed weights, one row per neuron
	// ------------------------------------------------------------------------
	localparam logic signed [dataWidth-1:0] weightTable [neuronCount][featureCount] = '{
		'{-8'sd29, 8'sd15, 8'sd13, -8'sd8, 8'sd31, -8'sd7, -8'sd2, 8'sd19,
			8'sd10, 8'sd17, -8'sd7, 8'sd1, -8'sd15, -8'sd4, 8'sd4, 8'sd18,
			-8'sd19, -8'sd16, -8'sd3, -8'sd26, 8'sd31, 8'sd31, 8'sd17, 8'sd6,
			8'sd2, 8'sd25, 8'sd9, 8'sd26, -8'sd17, -8'sd7},
		'{8'sd3, -8'sd12, 8'sd22, 8'sd7, -8'sd25, 8'sd11, 8'sd0, -8'sd5,
			8'sd18, -8'sd9, 8'sd27, -8'sd14, 8'sd6, 8'sd1, -8'sd20, 8'sd30,
			-8'sd3, 8'sd9, -8'sd17, 8'sd24, -8'sd8, 8'sd13, -8'sd29, 8'sd5,
			8'sd16, -8'sd1, -8'sd22, 8'sd10, 8'sd4, -8'sd11},
		'{-8'sd6, 8'sd21, -8'sd18, 8'sd14, 8'sd2, -8'sd27, 8'sd19, 8'sd8,
			-8'sd13, 8'sd25, -8'sd4, 8'sd17, -8'sd31, 8'sd12, 8'sd0, -8'sd10,
			8'sd23, -8'sd15, 8'sd7, -8'sd2, 8'sd28, -8'sd24, 8'sd11, -8'sd7,
			-8'sd19, 8'sd26, 8'sd3, -8'sd16, 8'sd20, 8'sd9},
		'{8'sd12, 8'sd5, -8'sd9, -8'sd21, 8'sd16, 8'sd8, -8'sd26, 8'sd29,
			-8'sd3, -8'sd14, 8'sd10, 8'sd22, -8'sd7, -8'sd18, 8'sd31, 8'sd4,
			-8'sd11, 8'sd15, 8'sd1, -8'sd23, 8'sd6, 8'sd19, -8'sd12, -8'sd30,
			8'sd9, 8'sd14, -8'sd5, 8'sd27, -8'sd8, 8'sd2}
	};

	// bias is as wide as one product
	localparam logic signed [productWidth-1:0] biasTable [neuronCount] = '{
		-16'sd512,
		-16'sd256,
		16'sd0,
		16'sd320
	};

endpackage

`default_nettype wire

/* design/featureLoader.sv */
`timescale 1ns/10ps
`default_nettype none

module featureLoader (
	input logic clk,
	input logic reset,
	input logic featureStrobe,
	input nnPkg::featureWord featureIn,
	output logic vectorStrobe,
	output nnPkg::featureVector vector
);

	typedef enum logic {
		idle,
		filling
	} loaderState;

	loaderState state;
	logic [$clog2(nnPkg::featureCount)-1:0] fillCount;

	// vector doubles as the byte shift register, oldest byte ends in element 0
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			fillCount <= '0;
			vectorStrobe <= 1'b0;
			vector <= '0;
		end
		else
		begin
			vectorStrobe <= 1'b0;
			if (featureStrobe)
			begin
				if (featureIn.kind == nnPkg::featStart)
				begin
					// opens a frame, drops any partial one
					state <= filling;
					fillCount <= '0;
				end
				else if (state == filling)
				begin
					vector.feature <= {vector.feature[1:nnPkg::featureCount-1],
						featureIn.data};
					if (int'(fillCount) == nnPkg::featureCount - 1)
					begin
						state <= idle; // last byte in
						vectorStrobe <= 1'b1;
					end
					else
						fillCount <= fillCount + 1'b1;
				end
				// data outside a frame is dropped
			end
		end
	end

endmodule

`default_nettype wire

/* design/neuron.sv */
`timescale 1ns/10ps
`default_nettype none

module neuron #(
	parameter int neuronIndex = 0
) (
	input logic clk,
	input logic reset,
	input nnPkg::featureVector vector,
	output logic [nnPkg::dataWidth-1:0] activation
);

	nnPkg::featureVector inReg;
	logic signed [nnPkg::productWidth-1:0] product [nnPkg::featureCount];
	logic [nnPkg::sumWidth-1:0] sumNext;
	logic [nnPkg::sumWidth-1:0] sumReg;

	function automatic logic [nnPkg::sumWidth-1:0] widen(
		input logic [nnPkg::productWidth-1:0] x
	);
		return {{(nnPkg::sumWidth - nnPkg::productWidth){x[nnPkg::productWidth-1]}}, x};
	endfunction

	// ------------------------------------------------------------------------
	// products and accumulation
	// ------------------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			product[i] = $signed(inReg.feature[i]) * nnPkg::weightTable[neuronIndex][i];
		end
	end

	always_comb
	begin
		sumNext = widen(nnPkg::biasTable[neuronIndex]);
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			sumNext = sumNext + widen(product[i]);
		end
	end

	// ------------------------------------------------------------------------
	// input, sum and activation registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inReg <= vector;
			sumReg <= sumNext;
			if (sumReg[nnPkg::sumWidth-1])
				activation <= '0; // rectifier
			else if (|sumReg[nnPkg::sumWidth-2:nnPkg::dataWidth+nnPkg::fracBits-1])
				activation <= nnPkg::satLevel;
			else
			begin
				// drop fraction bits, round half up
				activation <= sumReg[nnPkg::dataWidth+nnPkg::fracBits-1:nnPkg::fracBits]
					+ {{(nnPkg::dataWidth-1){1'b0}}, sumReg[nnPkg::fracBits-1]};
			end
		end
	end

endmodule

`default_nettype wire

/* design/denseLayer.sv */
`timescale 1ns/10ps
`default_nettype none

module denseLayer (
	input logic clk,
	input logic reset,
	input logic vectorStrobe,
	input nnPkg::featureVector vector,
	output logic layerStrobe,
	output nnPkg::layerOutput activations
);

	logic [2:0] strobePipe; // one bit per neuron stage
	logic [nnPkg::dataWidth-1:0] neuronOut [nnPkg::neuronCount];

	always_ff @(posedge clk)
	begin
		if (reset)
			strobePipe <= '0;
		else
			strobePipe <= {strobePipe[1:0], vectorStrobe};
	end

	assign layerStrobe = strobePipe[2];

	for (genvar n = 0; n < nnPkg::neuronCount; n++)
	begin : neuronGen
		neuron #(.neuronIndex(n)) neuron_i (
			.clk(clk),
			.reset(reset),
			.vector(vector),
			.activation(neuronOut[n])
		);
	end

	always_comb
	begin
		for (int n = 0; n < nnPkg::neuronCount; n++)
		begin
			activations.activation[n] = neuronOut[n];
		end
	end

endmodule

`default_nettype wire

/* design/classSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module classSelect (
	input logic clk,
	input logic reset,
	input logic layerStrobe,
	input nnPkg::layerOutput activations,
	output logic resultStrobe,
	output nnPkg::classResult result
);

	logic [nnPkg::classWidth-1:0] bestIndex;
	logic [nnPkg::dataWidth-1:0] bestScore;

	// ------------------------------------------------------------------------
	// argmax, strict compare keeps the lowest index on ties
	// ------------------------------------------------------------------------
	always_comb
	begin
		bestIndex = '0;
		bestScore = activations.activation[0];
		for (int n = 1; n < nnPkg::neuronCount; n++)
		begin
			if (activations.activation[n] > bestScore)
			begin
				bestIndex = n[nnPkg::classWidth-1:0];
				bestScore = activations.activation[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultStrobe <= 1'b0;
			result <= '0;
		end
		else
		begin
			resultStrobe <= layerStrobe;
			if (layerStrobe)
			begin
				result.classIndex <= bestIndex;
				result.score <= bestScore;
			end
		end
	end

endmodule

`default_nettype wire

/* design/nnClassifier.sv */
`timescale 1ns/10ps
`default_nettype none

module nnClassifier (
	input logic clk,
	input logic reset,
	input logic featureStrobe,
	input nnPkg::featureWord featureIn,
	output nnPkg::layerOutput layerActivations,
	output logic resultStrobe,
	output nnPkg::classResult result
);

	logic vectorStrobe;
	nnPkg::featureVector vector;
	logic layerStrobe;

	featureLoader featureLoader_i (
		.clk(clk),
		.reset(reset),
		.featureStrobe(featureStrobe),
		.featureIn(featureIn),
		.vectorStrobe(vectorStrobe),
		.vector(vector)
	);

	denseLayer denseLayer_i (
		.clk(clk),
		.reset(reset),
		.vectorStrobe(vectorStrobe),
		.vector(vector),
		.layerStrobe(layerStrobe),
		.activations(layerActivations) // also seen at the top
	);

	classSelect classSelect_i (
		.clk(clk),
		.reset(reset),
		.layerStrobe(layerStrobe),
		.activations(layerActivations),
		.resultStrobe(resultStrobe),
		.result(result)
	);

endmodule

`default_nettype wire

/* sim/nnClassifier_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module nnClassifier_assert (
	input logic clk,
	input logic reset,
	input logic resultStrobe,
	input nnPkg::classResult result
);

	// low during reset and in the first cycle after it
	strobeLowAfterReset: assert property (@(posedge clk) reset |=> !resultStrobe)
		else $error("resultStrobe high during or right after reset");

	strobeSingleCycle: assert property (@(posedge clk) disable iff (reset)
		resultStrobe |=> !resultStrobe) // frames are 31 cycles at least
		else $error("resultStrobe high on two consecutive cycles");

	scoreInRange: assert property (@(posedge clk) disable iff (reset)
		result.score <= 8'd128)
		else $error("result.score above 128");

endmodule

bind nnClassifier nnClassifier_assert nnClassifier_assert_i (
	.clk(clk),
	.reset(reset),
	.resultStrobe(resultStrobe),
	.result(result)
);

`default_nettype wire

/* sim/nnClassifierTb.sv */
`timescale 1ns/10ps
`default_nettype none

module nnClassifierTb;

	localparam int resultsTotal = 28;
	localparam int framesSent = resultsTotal + 3; // plus the partial frame and the stray words
	localparam int timeoutCycles = framesSent * 40 + 200;

	typedef struct packed {
		nnPkg::layerOutput act;
		nnPkg::classResult res;
		logic [31:0] cycle; // cycle in which resultStrobe is due
	} expectEntry;

	logic clk;
	logic reset;
	logic featureStrobe;
	nnPkg::featureWord featureIn;
	nnPkg::layerOutput layerActivations;
	logic resultStrobe;
	nnPkg::classResult result;

	expectEntry expectQueue [$];
	int cycleCount = 0;
	int resultCount = 0;

	nnClassifier nnClassifier_i (
		.clk(clk),
		.reset(reset),
		.featureStrobe(featureStrobe),
		.featureIn(featureIn),
		.layerActivations(layerActivations),
		.resultStrobe(resultStrobe),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic nnPkg::layerOutput modelLayer(input nnPkg::featureVector v);
		nnPkg::layerOutput a;
		int sum;
		for (int n = 0; n < nnPkg::neuronCount; n++)
		begin
			sum = int'(nnPkg::biasTable[n]);
			for (int i = 0; i < nnPkg::featureCount; i++)
				sum += int'($signed(v.feature[i])) * int'(nnPkg::weightTable[n][i]);
			if (sum < 0)
				a.activation[n] = 8'd0;
			else if (sum >= (1 << 13)) // some bit of 21..13 set
				a.activation[n] = 8'd127;
			else
				a.activation[n] = 8'((sum >> 6) + ((sum >> 5) & 1));
		end
		return a;
	endfunction

	function automatic nnPkg::classResult modelClass(input nnPkg::layerOutput a);
		nnPkg::classResult r;
		r.classIndex = 2'd0;
		r.score = a.activation[0];
		for (int n = 1; n < nnPkg::neuronCount; n++)
		begin
			if (a.activation[n] > r.score) // lowest index keeps a tie
			begin
				r.classIndex = 2'(n);
				r.score = a.activation[n];
			end
		end
		return r;
	endfunction

	function automatic nnPkg::featureVector randomVector();
		nnPkg::featureVector v;
		for (int i = 0; i < nnPkg::featureCount; i++)
			v.feature[i] = 8'($urandom);
		return v;
	endfunction

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------
	task automatic failRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkLayer(input nnPkg::layerOutput expected);
		for (int n = 0; n < nnPkg::neuronCount; n++)
			checkValue($sformatf("layerActivations[%0d]", n), expected.activation[n],
				layerActivations.activation[n]);
	endtask

	task automatic checkResult();
		expectEntry entry;
		if (expectQueue.size() == 0)
		begin
			$display("resultStrobe high at %0t with no frame outstanding", $time);
			failRun();
		end
		else
		begin
			entry = expectQueue.pop_front();
			checkValue("resultStrobe cycle", entry.cycle, cycleCount);
			checkValue("result.classIndex", entry.res.classIndex, result.classIndex);
			checkValue("result.score", entry.res.score, result.score);
			resultCount++;
		end
	endtask

	// sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (expectQueue.size() != 0 && cycleCount == int'(expectQueue[0].cycle) - 1)
			checkLayer(expectQueue[0].act);
		if (resultStrobe)
			checkResult();
		else if (expectQueue.size() != 0 && cycleCount >= int'(expectQueue[0].cycle))
		begin
			$display("resultStrobe missing at %0t, it was due in cycle %0d", $time,
				expectQueue[0].cycle);
			failRun();
		end
	end

	initial
	begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not complete", timeoutCycles);
		failRun();
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic sendWord(input nnPkg::featureKind kind, input logic [7:0] data);
		featureStrobe = 1'b1;
		featureIn.kind = kind;
		featureIn.data = data;
		@(posedge clk);
		#1;
		featureStrobe = 1'b0;
	endtask

	task automatic streamFrame(input nnPkg::featureVector v, input bit gaps,
		output int lastCycle);
		sendWord(nnPkg::featStart, 8'($urandom)); // data byte ignored
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			if (gaps && $urandom_range(0, 7) == 0)
				idleCycles($urandom_range(1, 3));
			lastCycle = cycleCount;
			sendWord(nnPkg::featData, v.feature[i]);
		end
	endtask

	task automatic expectFrame(input nnPkg::layerOutput act, input nnPkg::classResult res,
		input int lastCycle);
		expectEntry entry;
		entry.act = act;
		entry.res = res;
		entry.cycle = lastCycle + 5;
		expectQueue.push_back(entry);
	endtask

	task automatic sendFrame(input nnPkg::featureVector v, input bit gaps);
		int lastCycle;
		nnPkg::layerOutput act;
		streamFrame(v, gaps, lastCycle);
		act = modelLayer(v);
		expectFrame(act, modelClass(act), lastCycle);
	endtask

	task automatic waitResults();
		int waited;
		waited = 0;
		while (expectQueue.size() != 0 && waited < 20)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expectQueue.size() != 0)
		begin
			$display("Timed out waiting for resultStrobe, %0d results outstanding",
				expectQueue.size());
			failRun();
		end
		else
			idleCycles(8); // room for a stray extra strobe
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic testBiasOnly();
		nnPkg::layerOutput act;
		nnPkg::classResult res;
		int lastCycle;
		streamFrame('0, 1'b0, lastCycle);
		act.activation = {8'd0, 8'd0, 8'd0, 8'd5}; // 320 >> 6
		res.classIndex = 2'd3;
		res.score = 8'd5;
		expectFrame(act, res, lastCycle);
		waitResults();
	endtask

	task automatic testRandomFrames();
		for (int f = 0; f < 20; f++)
			sendFrame(randomVector(), 1'b1);
		waitResults();
	endtask

	task automatic testSaturation();
		nnPkg::featureVector v;
		for (int i = 0; i < nnPkg::featureCount; i++)
			v.feature[i] = (nnPkg::weightTable[0][i] < 0) ? 8'h81 : 8'h7f;
		sendFrame(v, 1'b0);
		for (int i = 0; i < nnPkg::featureCount; i++)
			v.feature[i] = 8'(-v.feature[i]);
		sendFrame(v, 1'b0);
		waitResults();
	endtask

	task automatic testRestart();
		repeat (nnPkg::featureCount)
			sendWord(nnPkg::featData, 8'($urandom)); // no frame open yet
		sendWord(nnPkg::featStart, 8'h00);
		repeat (12)
			sendWord(nnPkg::featData, 8'($urandom));
		sendFrame(randomVector(), 1'b0);
		repeat (nnPkg::featureCount)
			sendWord(nnPkg::featData, 8'($urandom)); // a whole frame's worth if accepted
		waitResults();
	endtask

	task automatic testBackToBack();
		nnPkg::featureVector tieVector;
		int pairWeight;
		// neurons 1 and 2 both saturate here
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			pairWeight = int'(nnPkg::weightTable[1][i]) + int'(nnPkg::weightTable[2][i]);
			tieVector.feature[i] = (pairWeight < 0) ? 8'h81 : 8'h7f;
		end
		sendFrame(randomVector(), 1'b0);
		sendFrame(tieVector, 1'b0);
		sendFrame(randomVector(), 1'b0);
		sendFrame('0, 1'b0);
		waitResults();
	endtask

	initial
	begin
		void'($urandom(58479));
		reset = 1'b1;
		featureStrobe = 1'b0;
		featureIn = '0;
		idleCycles(10);
		reset = 1'b0;

		testBiasOnly();
		testRandomFrames();
		testSaturation();
		testRestart();
		testBackToBack();

		if (resultCount == resultsTotal)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Saw %0d results instead of %0d", resultCount, resultsTotal);
			failRun();
		end
	end

endmodule

`default_nettype wire

/* files.f */
design/nnPkg.sv
design/featureLoader.sv
design/neuron.sv
design/denseLayer.sv
design/classSelect.sv
design/nnClassifier.sv
sim/nnClassifier_assert.sv
sim/nnClassifierTb.sv

/* Makefile */
BIN := obj_dir/VnnClassifierTb

.PHONY: all run clean

all: run

$(BIN): files.f $(wildcard design/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module nnClassifierTb -Mdir obj_dir -o VnnClassifierTb -f files.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
